/* blackjack_top.f */
design/blackjack_pkg.sv
design/card_source.sv
design/hand_accumulator.sv
design/round_controller.sv
design/blackjack_top.sv
dv/blackjack_tb.sv

/* design/blackjack_pkg.sv */
/*
 * Shared limits and types for the blackjack round controller.
 * Card values run from 1 to 10. An ace always counts as 1, so a hand
 * has no soft total. One player against one dealer per round.
 * Widths are sized for the worst reachable total, 21 + 10 = 31.
 */
package blackjack_pkg;

    // ----------------------------------------
    // game limits
    // ----------------------------------------
    localparam int CARD_BITS  = 4;   // one card value from 1 to 10
    localparam int TOTAL_BITS = 5;   // hand total up to 31
    localparam int COUNT_BITS = 4;   // cards held up to 9

    localparam int BUST_LIMIT   = 21;  // highest total still in play
    localparam int DEALER_STAND = 17;  // dealer stops drawing here
    localparam int MAX_CARDS    = 9;   // hand capacity

    // card source
    localparam int LFSR_BITS = 13;
    localparam logic [LFSR_BITS-1:0] LFSR_SEED = 13'h0b5d;  // any nonzero value

    // ----------------------------------------
    // scalar types
    // ----------------------------------------
    typedef logic [CARD_BITS-1:0]  card_value_t;
    typedef logic [TOTAL_BITS-1:0] hand_total_t;
    typedef logic [COUNT_BITS-1:0] card_count_t;

    // ----------------------------------------
    // bundles
    // ----------------------------------------

    // one dealt card that is valid for a single cycle
    typedef struct packed {
        logic        valid;
        logic        to_dealer;  // 0 sends the card to the player
        card_value_t value;
    } card_event_t;

    // summary of one hand as seen by the controller and the outside
    typedef struct packed {
        hand_total_t total;
        card_count_t count;
        logic        bust;       // total above BUST_LIMIT
    } hand_status_t;

    // round outcome held until the next round starts
    typedef enum logic [1:0] {
        RESULT_NONE       = 2'd0,
        RESULT_PLAYER_WIN = 2'd1,
        RESULT_DEALER_WIN = 2'd2,
        RESULT_DRAW       = 2'd3
    } round_result_t;

endpackage

/* design/blackjack_top.sv */
/*
 * Blackjack round, one player against the dealer.
 * start, hit and stand are single-cycle strobes, ignored outside the
 * state that expects them. Every dealt card is visible on card_event.
 */
`timescale 1ns/100ps

module blackjack_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        hit,
    input  logic                        stand,
    output blackjack_pkg::card_event_t   card_event,
    output blackjack_pkg::hand_status_t  player_status,
    output blackjack_pkg::hand_status_t  dealer_status,
    output logic                        player_turn,
    output blackjack_pkg::round_result_t result,
    output logic                        result_valid
);

    blackjack_pkg::card_value_t card_value;
    logic                       new_round;

    // ----------------------------------------
    // card stream
    // ----------------------------------------
    card_source card_source_inst (
        .clk        (clk),
        .rst        (rst),
        .card_value (card_value)
    );

    // ----------------------------------------
    // two hands built from the same block
    // ----------------------------------------
    hand_accumulator #(
        .DEALER_HAND (1'b0)
    ) player_hand (
        .clk        (clk),
        .rst        (rst),
        .new_round  (new_round),
        .card_event (card_event),
        .status     (player_status)
    );

    hand_accumulator #(
        .DEALER_HAND (1'b1)
    ) dealer_hand (
        .clk        (clk),
        .rst        (rst),
        .new_round  (new_round),
        .card_event (card_event),
        .status     (dealer_status)
    );

    // ----------------------------------------
    // round FSM
    // ----------------------------------------
    round_controller round_controller_inst (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .hit           (hit),
        .stand         (stand),
        .card_value    (card_value),
        .player_status (player_status),
        .dealer_status (dealer_status),
        .new_round     (new_round),
        .card_event    (card_event),
        .player_turn   (player_turn),
        .result        (result),
        .result_valid  (result_valid)
    );

endmodule

/* design/card_source.sv */
/*
 * Free-running pseudo-random card source.
 * The LFSR steps on every clock, whether or not a card is taken, so the
 * sequence a round sees depends on when start arrives.
 * Nibbles 11..15 all read as 10, as face cards do, and 0 reads as 1,
 * which makes 10 and 1 more likely than the other values.
 */
`timescale 1ns/100ps

module card_source (
    input  logic                      clk,
    input  logic                      rst,
    output blackjack_pkg::card_value_t card_value
);

    // ----------------------------------------
    // 13-bit Fibonacci LFSR
    // ----------------------------------------
    logic [blackjack_pkg::LFSR_BITS-1:0] lfsr;
    logic                                feedback;

    // taps 13, 4, 3, 1 give the full 8191-state cycle
    assign feedback = lfsr[12] ^ lfsr[3] ^ lfsr[2] ^ lfsr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= blackjack_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[11:0], feedback};
        end
    end

    // ----------------------------------------
    // nibble to card value
    // ----------------------------------------
    function automatic blackjack_pkg::card_value_t to_card(input logic [3:0] nib);
        if (nib == 4'd0) begin
            return blackjack_pkg::card_value_t'(1);
        end else if (nib > 4'd10) begin
            return blackjack_pkg::card_value_t'(10);  // jack, queen, king and spares
        end else begin
            return blackjack_pkg::card_value_t'(nib);
        end
    endfunction

    assign card_value = to_card(lfsr[3:0]);

    // the all-zero state would freeze the source on a single value
    lfsr_nonzero_a: assert property (@(posedge clk) disable iff (rst)
        lfsr != '0)
        else $error("card source LFSR reached the all-zero state");

endmodule

/* design/hand_accumulator.sv */
/*
 * Running total and card count for one hand.
 * DEALER_HAND picks which side of the card stream this instance takes.
 * The status lags a card event by one cycle. new_round wins over a card
 * in the same cycle, so the controller never deals during the clear.
 */
`timescale 1ns/100ps

module hand_accumulator #(
    parameter bit DEALER_HAND = 1'b0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_round,
    input  blackjack_pkg::card_event_t  card_event,
    output blackjack_pkg::hand_status_t status
);

    blackjack_pkg::hand_total_t total_q;
    blackjack_pkg::card_count_t count_q;
    logic                       mine;  // card addressed to this hand
    logic                       bust;

    assign mine = card_event.valid && (card_event.to_dealer == DEALER_HAND);

    // ----------------------------------------
    // total and count
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst || new_round) begin
            total_q <= '0;
            count_q <= '0;
        end else if (mine) begin
            total_q <= total_q + blackjack_pkg::hand_total_t'(card_event.value);
            count_q <= count_q + 1'b1;
        end
    end

    assign bust = (total_q > blackjack_pkg::BUST_LIMIT);

    assign status = '{
        total: total_q,
        count: count_q,
        bust:  bust
    };

    // ----------------------------------------
    // checks against the controller
    // ----------------------------------------

    // controller stops dealing at capacity
    count_limit_a: assert property (@(posedge clk) disable iff (rst)
        count_q <= blackjack_pkg::MAX_CARDS)
        else $error("hand holds more than MAX_CARDS cards");

    // a bust hand ends its turn so nothing more should reach it
    no_card_when_bust_a: assert property (@(posedge clk) disable iff (rst)
        mine |-> !bust)
        else $error("card dealt to a hand that is already bust");

endmodule

/* design/round_controller.sv */
/*
 * Round FSM: clear, three-card deal, player turn, dealer rule, verdict.
 * start is taken only when idle or after a result; hit and stand only
 * during the player turn. A hit with a full hand is dropped.
 * Deal cards show up in their own deal state. A drawn card shows up one
 * cycle after its draw state, and the check state waits for it to land.
 * The result holds until the next accepted start.
 */
`timescale 1ns/100ps

module round_controller (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        hit,
    input  logic                        stand,
    input  blackjack_pkg::card_value_t   card_value,
    input  blackjack_pkg::hand_status_t  player_status,
    input  blackjack_pkg::hand_status_t  dealer_status,
    output logic                        new_round,
    output blackjack_pkg::card_event_t   card_event,
    output logic                        player_turn,
    output blackjack_pkg::round_result_t result,
    output logic                        result_valid
);

    typedef enum logic [3:0] {
        IDLE,
        CLEAR,
        DEAL_P1,
        DEAL_P2,
        DEAL_D,
        SETTLE,
        PLAYER_TURN,
        PLAYER_DRAW,
        PLAYER_CHECK,
        DEALER_CHECK,
        DEALER_DRAW,
        DONE
    } state_t;

    state_t                        state;
    state_t                        state_nxt;
    logic                          player_room;   // player may still take a card
    logic                          dealer_draws;  // dealer rule says draw
    logic                          draw_now;
    logic                          draw_to_dealer;
    blackjack_pkg::round_result_t  verdict;

    assign player_room  = player_status.count < blackjack_pkg::MAX_CARDS;
    assign dealer_draws = (dealer_status.total < blackjack_pkg::DEALER_STAND)
                       && (dealer_status.count < blackjack_pkg::MAX_CARDS);

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: begin
                if (start) begin
                    state_nxt = CLEAR;
                end
            end
            CLEAR:   state_nxt = DEAL_P1;
            DEAL_P1: state_nxt = DEAL_P2;
            DEAL_P2: state_nxt = DEAL_D;
            DEAL_D:  state_nxt = SETTLE;
            SETTLE:  state_nxt = PLAYER_TURN;  // dealer card lands here
            PLAYER_TURN: begin
                if (hit && player_room) begin
                    state_nxt = PLAYER_DRAW;
                end else if (stand) begin
                    state_nxt = DEALER_CHECK;
                end
            end
            PLAYER_DRAW: state_nxt = PLAYER_CHECK;
            PLAYER_CHECK: begin
                if (!card_event.valid) begin  // status has absorbed the card
                    state_nxt = player_status.bust ? DONE : PLAYER_TURN;
                end
            end
            DEALER_CHECK: begin
                if (!card_event.valid) begin
                    state_nxt = dealer_draws ? DEALER_DRAW : DONE;
                end
            end
            DEALER_DRAW: state_nxt = DEALER_CHECK;
            default:     state_nxt = IDLE;
        endcase
    end

    // deal cards are registered on entry, drawn cards on leaving the draw state
    assign draw_now = (state_nxt inside {DEAL_P1, DEAL_P2, DEAL_D})
                   || (state inside {PLAYER_DRAW, DEALER_DRAW});
    assign draw_to_dealer = (state_nxt == DEAL_D) || (state == DEALER_DRAW);

    // ----------------------------------------
    // verdict, in rule order
    // ----------------------------------------
    always_comb begin
        if (player_status.bust) begin
            verdict = blackjack_pkg::RESULT_DEALER_WIN;
        end else if (dealer_status.bust) begin
            verdict = blackjack_pkg::RESULT_PLAYER_WIN;
        end else if (player_status.total > dealer_status.total) begin
            verdict = blackjack_pkg::RESULT_PLAYER_WIN;
        end else if (dealer_status.total > player_status.total) begin
            verdict = blackjack_pkg::RESULT_DEALER_WIN;
        end else begin
            verdict = blackjack_pkg::RESULT_DRAW;
        end
    end

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= IDLE;
            card_event.valid <= 1'b0;
            result           <= blackjack_pkg::RESULT_NONE;
            result_valid     <= 1'b0;
        end else begin
            state            <= state_nxt;
            card_event.valid <= draw_now;
            if (state_nxt == CLEAR) begin
                result       <= blackjack_pkg::RESULT_NONE;
                result_valid <= 1'b0;
            end else if (state_nxt == DONE && state != DONE) begin
                result       <= verdict;  // statuses are settled in both check states
                result_valid <= 1'b1;
            end
        end
        card_event.to_dealer <= draw_to_dealer;
        card_event.value     <= card_value;
    end

    assign new_round   = (state == CLEAR);
    assign player_turn = (state == PLAYER_TURN);

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    turn_result_excl_a: assert property (@(posedge clk) disable iff (rst)
        !(player_turn && result_valid))
        else $error("player turn open while a result is shown");

    // a drawn card must land while its check state is waiting for it
    card_in_draw_a: assert property (@(posedge clk) disable iff (rst)
        card_event.valid |-> state inside {DEAL_P1, DEAL_P2, DEAL_D,
                                           PLAYER_CHECK, DEALER_CHECK})
        else $error("card event outside a drawing state");

endmodule

/* dv/blackjack_tb.sv */
/*
 * Testbench for blackjack_top, driven from a table of rounds.
 * Each row sets the hits before standing and which stray strobes to send.
 * A scorer follows card_event and rebuilds both hands and the verdict.
 * Inputs change 1 ns after the rising edge, and outputs are sampled there.
 */
`timescale 1ns/100ps

module blackjack_tb;

    localparam int NUM_ROWS       = 12;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;

    typedef struct packed {
        logic [2:0] hits;          // hits before standing
        logic       stray_pulses;  // hit and stand before start
        logic       stray_start;   // start during the player turn
    } row_t;

    logic                         clk;
    logic                         rst;
    logic                         start;
    logic                         hit;
    logic                         stand;
    blackjack_pkg::card_event_t   card_event;
    blackjack_pkg::hand_status_t  player_status;
    blackjack_pkg::hand_status_t  dealer_status;
    logic                         player_turn;
    blackjack_pkg::round_result_t result;
    logic                         result_valid;

    row_t   rows [NUM_ROWS];
    integer seed;
    int     cycles;
    int     errors;
    int     p_total;       // scorer's player side
    int     p_count;
    int     d_total;       // scorer's dealer side
    int     d_count;
    int     round_events;  // cards seen this round
    int     total_events;
    logic   stood;

    blackjack_top blackjack_top_inst (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .hit           (hit),
        .stand         (stand),
        .card_event    (card_event),
        .player_status (player_status),
        .dealer_status (dealer_status),
        .player_turn   (player_turn),
        .result        (result),
        .result_valid  (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // checking and scoring
    // ----------------------------------------
    task automatic check_value(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s (got %0d, expected %0d)", $time, what, actual, expected);
            $display(">>> FAIL");
            errors++;
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_hand(input blackjack_pkg::hand_status_t st, input int total,
                              input int count, input string who);
        check_value(int'(st.total), total, {who, " total"});
        check_value(int'(st.count), count, {who, " card count"});
        check_value(int'(st.bust), int'(total > blackjack_pkg::BUST_LIMIT), {who, " bust flag"});
    endtask

    // result rule in order of player bust, dealer bust, higher total and a draw
    function automatic blackjack_pkg::round_result_t expected_result(input int p, input int d);
        if (p > blackjack_pkg::BUST_LIMIT) begin
            return blackjack_pkg::RESULT_DEALER_WIN;
        end else if (d > blackjack_pkg::BUST_LIMIT) begin
            return blackjack_pkg::RESULT_PLAYER_WIN;
        end else if (p > d) begin
            return blackjack_pkg::RESULT_PLAYER_WIN;
        end else if (d > p) begin
            return blackjack_pkg::RESULT_DEALER_WIN;
        end else begin
            return blackjack_pkg::RESULT_DRAW;
        end
    endfunction

    task automatic score_card();
        int value;
        value = int'(card_event.value);
        check_value(int'(value >= 1 && value <= 10), 1, "card value outside 1..10");
        if (round_events < 3) begin
            check_value(int'(card_event.to_dealer), int'(round_events == 2), "deal order");
        end
        if (card_event.to_dealer) begin
            if (d_count >= 1) begin  // dealer rule applies past the deal
                check_value(int'(stood), 1, "dealer card before stand");
                check_value(int'(d_total < blackjack_pkg::DEALER_STAND), 1,
                            "dealer drew at or above its stand total");
            end
            d_total += value;
            d_count++;
        end else begin
            if (round_events >= 3) begin  // only a hit brings a later player card
                check_value(int'(stood), 0, "player card after stand");
            end
            p_total += value;
            p_count++;
        end
        round_events++;
        total_events++;
    endtask

    // one clock with the timeout and the card monitor
    task automatic tick();
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("simulation hung waiting for the DUT after %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end else if (card_event.valid) begin
            score_card();
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) tick();
    endtask

    // ----------------------------------------
    // round steps
    // ----------------------------------------
    task automatic send_stray_pulses();
        int ev;
        int saved_valid;
        int saved_result;
        ev           = total_events;
        saved_valid  = int'(result_valid);
        saved_result = int'(result);
        hit = 1'b1;
        tick();
        hit = 1'b0;
        idle_gap();
        stand = 1'b1;
        tick();
        stand = 1'b0;
        tick();
        tick();
        check_value(total_events, ev, "stray strobe produced a card");
        check_value(int'(result_valid), saved_valid, "stray strobe moved result_valid");
        check_value(int'(result), saved_result, "stray strobe moved result");
        check_value(int'(player_turn), 0, "stray strobe opened a player turn");
    endtask

    task automatic open_round();
        int turn_wait;
        p_total      = 0;
        p_count      = 0;
        d_total      = 0;
        d_count      = 0;
        round_events = 0;
        stood        = 1'b0;
        start = 1'b1;
        tick();
        start = 1'b0;
        check_value(int'(result_valid), 0, "result_valid after start");
        check_value(int'(result), int'(blackjack_pkg::RESULT_NONE), "result after start");
        tick();  // hands cleared by now
        check_value(int'(player_status), 0, "player status cleared");
        check_value(int'(dealer_status), 0, "dealer status cleared");
        turn_wait = 2;
        while (!player_turn) begin
            tick();
            turn_wait++;
        end
        check_value(turn_wait, 6, "cycles from start to player turn");
        check_value(round_events, 3, "cards in the opening deal");
        check_hand(player_status, p_total, 2, "player after deal");
        check_hand(dealer_status, d_total, 1, "dealer after deal");
    endtask

    task automatic stray_start_in_turn();
        blackjack_pkg::hand_status_t saved_p;
        blackjack_pkg::hand_status_t saved_d;
        int ev;
        saved_p = player_status;
        saved_d = dealer_status;
        ev      = round_events;
        start = 1'b1;
        tick();
        start = 1'b0;
        tick();
        check_value(int'(player_turn), 1, "start during player turn closed the turn");
        check_value(round_events, ev, "start during player turn dealt a card");
        check_value(int'(player_status), int'(saved_p), "start during turn moved player");
        check_value(int'(dealer_status), int'(saved_d), "start during turn moved dealer");
    endtask

    task automatic take_hit();
        int before_p;
        int before_d;
        before_p = p_count;
        before_d = d_count;
        hit = 1'b1;
        tick();
        hit = 1'b0;
        while (!player_turn && !result_valid) begin
            tick();
        end
        check_value(p_count, before_p + 1, "player cards per hit");
        check_value(d_count, before_d, "dealer card on a hit");
        check_hand(player_status, p_total, p_count, "player after hit");
        if (p_total > blackjack_pkg::BUST_LIMIT) begin
            check_value(int'(result_valid), 1, "no result after player bust");
        end else begin
            check_value(int'(player_turn), 1, "player turn not back after hit");
        end
    endtask

    task automatic check_verdict();
        check_value(int'(result_valid), 1, "result_valid at round end");
        check_value(int'(player_turn), 0, "player turn at round end");
        check_hand(player_status, p_total, p_count, "player at result");
        check_hand(dealer_status, d_total, d_count, "dealer at result");
        if (p_total > blackjack_pkg::BUST_LIMIT) begin
            check_value(d_count, 1, "dealer drew after a player bust");
        end else begin
            // a full dealer hand also ends the draw
            check_value(int'(d_total >= blackjack_pkg::DEALER_STAND
                             || d_count == blackjack_pkg::MAX_CARDS), 1,
                        "dealer stopped below its stand total");
        end
        check_value(int'(result), int'(expected_result(p_total, d_total)), "round result");
    endtask

    task automatic play_round(input row_t row);
        int h;
        if (row.stray_pulses) begin
            send_stray_pulses();
        end
        open_round();
        if (row.stray_start) begin
            stray_start_in_turn();
        end
        h = 0;
        while (h < int'(row.hits) && p_total <= blackjack_pkg::BUST_LIMIT) begin
            idle_gap();
            take_hit();
            h++;
        end
        if (p_total <= blackjack_pkg::BUST_LIMIT) begin
            idle_gap();
            stand = 1'b1;
            stood = 1'b1;
            tick();
            stand = 1'b0;
            while (!result_valid) begin
                tick();
            end
        end
        check_verdict();
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed         = 38710;
        cycles       = 0;
        errors       = 0;
        total_events = 0;
        round_events = 0;
        stood        = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        hit   = 1'b0;
        stand = 1'b0;
        //         hits  stray  start
        rows = '{
            '{3'd0, 1'b1, 1'b0},
            '{3'd1, 1'b0, 1'b1},
            '{3'd2, 1'b1, 1'b0},
            '{3'd3, 1'b0, 1'b0},
            '{3'd5, 1'b0, 1'b1},
            '{3'd0, 1'b0, 1'b0},
            '{3'd4, 1'b1, 1'b1},
            '{3'd1, 1'b0, 1'b0},
            '{3'd2, 1'b0, 1'b1},
            '{3'd5, 1'b1, 1'b0},
            '{3'd3, 1'b0, 1'b1},
            '{3'd0, 1'b1, 1'b1}
        };
        tick();
        tick();
        rst = 1'b0;
        tick();
        check_value(int'(player_turn), 0, "player_turn after reset");
        check_value(int'(result_valid), 0, "result_valid after reset");
        check_value(int'(card_event.valid), 0, "card event after reset");
        check_value(int'(result), int'(blackjack_pkg::RESULT_NONE), "result after reset");
        check_value(int'(player_status), 0, "player status after reset");
        check_value(int'(dealer_status), 0, "dealer status after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            play_round(rows[r]);
        end
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the blackjack testbench with Verilator, runs it, and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module blackjack_tb -f blackjack_top.f -o blackjack_sim \
    && ./obj_dir/blackjack_sim | tee "$LOG" \
    || { echo "build or run step failed"; exit 1; }

grep -q ">>> FAIL" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q ">>> PASS" "$LOG" || { echo "simulation ended without a verdict"; exit 1; }

echo "simulation finished cleanly"
exit 0
